// File: sim/tb_chip_top.sv
`timescale 1ns/1ps

module tb_chip_top
  import chip_tag_pkg::*;
  import chip_mem_pkg::*;
  ();

  localparam int pkt_cnt_c = 22;
  localparam int cmd_cnt_c = 24;
  localparam int watchdog_cycles_c = 20 * (pkt_cnt_c * 20 + 2 * cmd_cnt_c * 8);
  localparam logic [31:0] dmc_mask_c = 32'h0f0f_3c3c;
  localparam logic [31:0] byp_mask_c = 32'hf0f0_a5a5;

  // expected tag register contents
  typedef struct packed {
    ctrl_payload_s                         core;
    ctrl_payload_s                         host;
    ctrl_payload_s                         router;
    logic [7:0]                            byp;
    logic [dmc_cfg_bytes_c-1:0][7:0]       dmc;
  } tag_state_s;

  logic clk_i, rst_n_i, tag_data_i, tag_en_i;
  logic core_reset_o, host_reset_o, router_reset_o, dmc_sys_reset_o;
  logic [did_width_c-1:0] core_did_o, host_did_o, router_did_o;
  dmc_timing_s dmc_timing_o, exp_timing;
  logic mem_cmd_v_i, mem_cmd_ready_o, mem_resp_v_o, mem_resp_ready_i;
  logic dmc_cmd_v_o, dmc_cmd_ready_i, dmc_resp_v_i, dmc_resp_ready_o;
  logic byp_cmd_v_o, byp_cmd_ready_i, byp_resp_v_i, byp_resp_ready_o;
  mem_msg_s mem_cmd_i, mem_resp_o, dmc_cmd_o, dmc_resp_i, byp_cmd_o, byp_resp_i;

  logic pkt_last, pkt_en, byp_mode, traffic_on, exp_sel;
  logic [tag_id_width_c-1:0] pkt_id;
  logic [7:0] pkt_payload;
  tag_state_s exp_st, exp_d1, exp_d2;
  mem_msg_s exp_resp_q[$];

  tb_clk_gen #(.period_ns_p(8), .reset_cycles_p(2)) i_clk_gen (.clk_o(clk_i), .rst_n_o(rst_n_i));

  chip_top i_dut (.*);

  task automatic stop_on_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  function automatic mem_msg_s random_msg();
    return {mem_opcode_e'($urandom_range(0, 1)), mem_addr_width_c'($urandom), 32'($urandom)};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // reference model of the tag registers

  // updated on the edge that samples the last payload bit and seen two edges later
  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exp_st <= '0;
      exp_d1 <= '0;
      exp_d2 <= '0;
    end else begin
      if (pkt_last && pkt_en) begin
        case (pkt_id)
          tag_core_id_c:   exp_st.core   <= ctrl_payload_s'(pkt_payload[4:0]);
          tag_host_id_c:   exp_st.host   <= ctrl_payload_s'(pkt_payload[4:0]);
          tag_router_id_c: exp_st.router <= ctrl_payload_s'(pkt_payload[4:0]);
          tag_bypass_id_c: exp_st.byp    <= pkt_payload;
          default:         exp_st.dmc[pkt_id - tag_dmc_base_id_c] <= pkt_payload;
        endcase
      end
      exp_d1 <= exp_st;
      exp_d2 <= exp_d1;
    end
  end

  assign exp_sel    = exp_d2.byp[0];
  assign exp_timing = {exp_d2.dmc[1], exp_d2.dmc[0], exp_d2.dmc[2][3:0], exp_d2.dmc[2][7:4],
                       exp_d2.dmc[3][3:0], exp_d2.dmc[3][7:4], exp_d2.dmc[4][3:0],
                       exp_d2.dmc[4][7:4], exp_d2.dmc[5][3:0], exp_d2.dmc[5][7:4],
                       exp_d2.dmc[6][3:0], exp_d2.dmc[6][7:4], exp_d2.dmc[7][3:0],
                       exp_d2.dmc[8][3:0], exp_d2.dmc[8][7:4], exp_d2.dmc[9][1:0],
                       exp_d2.dmc[9][7:2], exp_d2.dmc[10][1:0], exp_d2.dmc[10][5:2]};

  ////////////////////////////////////////////////////////////////////////////
  // checks

  a_ctrl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    {core_reset_o, core_did_o} == exp_d2.core && {host_reset_o, host_did_o} == exp_d2.host
    && {router_reset_o, router_did_o} == exp_d2.router)
    else stop_on_error("control outputs differ from the written payloads");
  a_dmc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dmc_timing_o == exp_timing && dmc_sys_reset_o == exp_d2.dmc[11][0])
    else stop_on_error("dmc timing or system reset differ from the config bytes");
  a_cmd_steer: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dmc_cmd_v_o == (mem_cmd_v_i && !exp_sel) && byp_cmd_v_o == (mem_cmd_v_i && exp_sel)
    && dmc_cmd_o == mem_cmd_i && byp_cmd_o == mem_cmd_i)
    else stop_on_error("command valid or data steered to the wrong port");
  a_cmd_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_cmd_ready_o == (exp_sel ? byp_cmd_ready_i : dmc_cmd_ready_i))
    else stop_on_error("command ready not taken from the selected port");
  a_resp_merge: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_resp_v_o == (exp_sel ? byp_resp_v_i : dmc_resp_v_i)
    && mem_resp_o == (exp_sel ? byp_resp_i : dmc_resp_i))
    else stop_on_error("response not taken from the selected port");
  a_resp_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dmc_resp_ready_o == (mem_resp_ready_i && !exp_sel)
    && byp_resp_ready_o == (mem_resp_ready_i && exp_sel))
    else stop_on_error("response ready reached the unselected port");
  a_dmc_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dmc_cmd_v_o && !dmc_cmd_ready_i |=> dmc_cmd_v_o && $stable(dmc_cmd_o))
    else stop_on_error("stalled dmc command dropped or changed");
  a_byp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    byp_cmd_v_o && !byp_cmd_ready_i |=> byp_cmd_v_o && $stable(byp_cmd_o))
    else stop_on_error("stalled bypass command dropped or changed");
  a_resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_resp_v_o && !mem_resp_ready_i |=> mem_resp_v_o && $stable(mem_resp_o))
    else stop_on_error("stalled response dropped or changed");

  ////////////////////////////////////////////////////////////////////////////
  // memory endpoints and response sink

  // active port answers in order while the other one shows noise
  initial begin : port_models
    mem_msg_s q[$];
    mem_msg_s head;
    mem_msg_s junk;
    logic     head_v;
    dmc_cmd_ready_i = 1'b0;
    byp_cmd_ready_i = 1'b0;
    dmc_resp_v_i    = 1'b0;
    byp_resp_v_i    = 1'b0;
    dmc_resp_i      = '0;
    byp_resp_i      = '0;
    forever begin
      @(posedge clk_i);
      if (byp_mode ? (byp_resp_v_i && byp_resp_ready_o) : (dmc_resp_v_i && dmc_resp_ready_o)) begin
        void'(q.pop_front());
      end
      if (byp_mode ? (byp_cmd_v_o && byp_cmd_ready_i) : (dmc_cmd_v_o && dmc_cmd_ready_i)) begin
        head = byp_mode ? byp_cmd_o : dmc_cmd_o;
        head.data = head.data ^ (byp_mode ? byp_mask_c : dmc_mask_c);
        q.push_back(head);
      end
      head_v = (q.size() != 0);
      head   = head_v ? q[0] : '0;
      junk   = random_msg();
      dmc_cmd_ready_i <= 1'($urandom_range(0, 1));
      byp_cmd_ready_i <= 1'($urandom_range(0, 1));
      dmc_resp_v_i    <= byp_mode ? traffic_on : head_v;
      dmc_resp_i      <= byp_mode ? junk : head;
      byp_resp_v_i    <= byp_mode ? head_v : traffic_on;
      byp_resp_i      <= byp_mode ? head : junk;
    end
  end

  initial begin : resp_sink
    mem_msg_s exp_m;
    mem_resp_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      if (mem_resp_v_o && mem_resp_ready_i) begin
        assert (exp_resp_q.size() != 0) else stop_on_error("response without a command");
        exp_m = exp_resp_q.pop_front();
        assert (mem_resp_o == exp_m)
          else stop_on_error($sformatf("response %h, expected %h", mem_resp_o, exp_m));
      end
      mem_resp_ready_i <= 1'($urandom_range(0, 1));
    end
  end

  initial begin : watchdog
    repeat (watchdog_cycles_c) @(posedge clk_i);
    $display("timeout: the run did not finish within %0d cycles", watchdog_cycles_c);
    $display("=== FAIL ===");
    $fatal(1);
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus

  // start bit, id msb first, payload msb first
  task automatic send_packet(input logic [tag_id_width_c-1:0] id, input logic [7:0] payload,
                             input logic en);
    logic [tag_shift_bits_c:0] bits;
    bits = {1'b1, id, payload};
    for (int i = tag_shift_bits_c; i >= 0; i--) begin
      @(posedge clk_i);
      tag_data_i  <= bits[i];
      tag_en_i    <= en;
      pkt_last    <= (i == 0);
      pkt_id      <= id;
      pkt_payload <= payload;
      pkt_en      <= en;
    end
  endtask

  task automatic idle_line(input int n);
    repeat (n) begin
      @(posedge clk_i);
      tag_data_i <= 1'b0;
      tag_en_i   <= 1'b0;
      pkt_last   <= 1'b0;
    end
  endtask

  task automatic run_traffic(input int n);
    mem_msg_s m;
    mem_msg_s r;
    for (int i = 0; i < n; i++) begin
      @(posedge clk_i);
      m = random_msg();
      r = m;
      r.data = m.data ^ (byp_mode ? byp_mask_c : dmc_mask_c);
      exp_resp_q.push_back(r);
      mem_cmd_v_i <= 1'b1;
      mem_cmd_i   <= m;
      do begin
        @(posedge clk_i);
      end while (!mem_cmd_ready_o);
      mem_cmd_v_i <= 1'b0;
      mem_cmd_i   <= random_msg();
      repeat ($urandom_range(0, 2)) @(posedge clk_i);
    end
    while (exp_resp_q.size() != 0) @(posedge clk_i);
  endtask

  initial begin : stimulus
    void'($urandom(32'hdd49_7988));
    tag_data_i  = 1'b0;
    tag_en_i    = 1'b0;
    pkt_last    = 1'b0;
    pkt_en      = 1'b0;
    pkt_id      = '0;
    pkt_payload = '0;
    mem_cmd_v_i = 1'b0;
    mem_cmd_i   = '0;
    byp_mode    = 1'b0;
    traffic_on  = 1'b0;
    wait (rst_n_i === 1'b1);
    repeat (2) @(posedge clk_i);

    assert (!core_reset_o && !host_reset_o && !router_reset_o && core_did_o == '0
            && host_did_o == '0 && router_did_o == '0 && dmc_timing_o == '0
            && !dmc_sys_reset_o)
      else stop_on_error("outputs not cleared by reset");

    for (int k = 0; k < 6; k++) begin
      send_packet(tag_id_width_c'(k % 3), 8'($urandom), 1'b1);
    end
    idle_line(4);
    // a gated packet and then two back to back
    send_packet(tag_core_id_c, {3'($urandom), ~exp_st.core}, 1'b0);
    idle_line(4);
    send_packet(tag_host_id_c, {3'($urandom), ~exp_st.host}, 1'b1);
    send_packet(tag_router_id_c, {3'($urandom), ~exp_st.router}, 1'b1);
    idle_line(4);
    for (int i = 0; i < dmc_cfg_bytes_c; i++) begin
      send_packet(tag_dmc_base_id_c + tag_id_width_c'(i), 8'($urandom), 1'b1);
    end
    idle_line(4);

    @(posedge clk_i);
    traffic_on <= 1'b1;
    run_traffic(cmd_cnt_c);
    @(posedge clk_i);
    traffic_on <= 1'b0;

    send_packet(tag_bypass_id_c, 8'($urandom) | 8'h01, 1'b1);
    idle_line(4);
    byp_mode   <= 1'b1;
    traffic_on <= 1'b1;
    run_traffic(cmd_cnt_c);

    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: sim/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen
  #(parameter int period_ns_p    = 8
   ,parameter int reset_cycles_p = 2
   )
  (output logic clk_o
  ,output logic rst_n_o
  );

  initial begin
    clk_o = 1'b0;
    forever #(period_ns_p / 2) clk_o = ~clk_o;
  end

  // release on a rising edge so the first active cycle is a full one
  initial begin
    rst_n_o = 1'b0;
    repeat (reset_cycles_p) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// File: source/chip_dmc_cfg.sv
`timescale 1ns/1ps

module chip_dmc_cfg
  import chip_tag_pkg::*;
  import chip_mem_pkg::*;
  (input  logic        clk_i
  ,input  logic        rst_n_i
  ,input  tag_write_s  tag_write_i
  ,output dmc_timing_s dmc_timing_o
  ,output logic        dmc_sys_reset_o
  );

  logic [dmc_cfg_bytes_c-1:0][tag_payload_width_c-1:0] cfg_bytes_lo;

  ////////////////////////////////////////////////////////////////////////////
  // one byte client per config byte

  for (genvar i = 0; i < tag_dmc_num_c; i++) begin : g_byte
    chip_tag_client
      #(.payload_t  ( logic [tag_payload_width_c-1:0] )
       ,.client_id_p( tag_dmc_base_id_c + tag_id_width_c'(i) )
       )
      i_client
        (.clk_i      ( clk_i )
        ,.rst_n_i    ( rst_n_i )
        ,.tag_write_i( tag_write_i )
        ,.data_o     ( cfg_bytes_lo[i] )
        ,.new_o      ()
        );
  end

  ////////////////////////////////////////////////////////////////////////////
  // unpack into timing fields

  // refresh interval, byte 1 is the high half
  assign dmc_timing_o.trefi        = {cfg_bytes_lo[1], cfg_bytes_lo[0]};

  assign dmc_timing_o.tmrd         = cfg_bytes_lo[2][3:0];
  assign dmc_timing_o.trfc         = cfg_bytes_lo[2][7:4];
  assign dmc_timing_o.trc          = cfg_bytes_lo[3][3:0];
  assign dmc_timing_o.trp          = cfg_bytes_lo[3][7:4];
  assign dmc_timing_o.tras         = cfg_bytes_lo[4][3:0];
  assign dmc_timing_o.trrd         = cfg_bytes_lo[4][7:4];
  assign dmc_timing_o.trcd         = cfg_bytes_lo[5][3:0];
  assign dmc_timing_o.twr          = cfg_bytes_lo[5][7:4];
  assign dmc_timing_o.twtr         = cfg_bytes_lo[6][3:0];
  assign dmc_timing_o.trtp         = cfg_bytes_lo[6][7:4];
  assign dmc_timing_o.tcas         = cfg_bytes_lo[7][3:0];

  // address geometry
  assign dmc_timing_o.col_width    = cfg_bytes_lo[8][3:0];
  assign dmc_timing_o.row_width    = cfg_bytes_lo[8][7:4];
  assign dmc_timing_o.bank_width   = cfg_bytes_lo[9][1:0];
  assign dmc_timing_o.bank_pos     = cfg_bytes_lo[9][7:2];

  assign dmc_timing_o.dqs_sel_cal  = cfg_bytes_lo[10][1:0];
  assign dmc_timing_o.init_cmd_cnt = cfg_bytes_lo[10][5:2];

  assign dmc_sys_reset_o = cfg_bytes_lo[11][0];

endmodule

// File: source/chip_mem_pkg.sv
package chip_mem_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // memory command and response messages

  localparam int mem_addr_width_c = 28;
  localparam int mem_data_width_c = 32;

  typedef enum logic [1:0] {
    mem_op_rd_e = 2'b00,
    mem_op_wr_e = 2'b01
  } mem_opcode_e;

  typedef struct packed {
    mem_opcode_e                 opcode;
    logic [mem_addr_width_c-1:0] addr;
    logic [mem_data_width_c-1:0] data;
  } mem_msg_s;

  ////////////////////////////////////////////////////////////////////////////
  // dram controller configuration

  localparam int dmc_cfg_bytes_c = 12;

  typedef struct packed {
    logic [15:0] trefi;
    logic [3:0]  tmrd;
    logic [3:0]  trfc;
    logic [3:0]  trc;
    logic [3:0]  trp;
    logic [3:0]  tras;
    logic [3:0]  trrd;
    logic [3:0]  trcd;
    logic [3:0]  twr;
    logic [3:0]  twtr;
    logic [3:0]  trtp;
    logic [3:0]  tcas;
    logic [3:0]  col_width;
    logic [3:0]  row_width;
    logic [1:0]  bank_width;
    logic [5:0]  bank_pos;
    logic [1:0]  dqs_sel_cal;
    logic [3:0]  init_cmd_cnt;
  } dmc_timing_s;

endpackage

// File: source/chip_mem_switch.sv
`timescale 1ns/1ps

module chip_mem_switch
  import chip_mem_pkg::*;
  (input  logic     sel_i

  // memory source side
  ,input  logic     mem_cmd_v_i
  ,input  mem_msg_s mem_cmd_i
  ,output logic     mem_cmd_ready_o
  ,output logic     mem_resp_v_o
  ,output mem_msg_s mem_resp_o
  ,input  logic     mem_resp_ready_i

  // dram controller port
  ,output logic     dmc_cmd_v_o
  ,output mem_msg_s dmc_cmd_o
  ,input  logic     dmc_cmd_ready_i
  ,input  logic     dmc_resp_v_i
  ,input  mem_msg_s dmc_resp_i
  ,output logic     dmc_resp_ready_o

  // bypass port
  ,output logic     byp_cmd_v_o
  ,output mem_msg_s byp_cmd_o
  ,input  logic     byp_cmd_ready_i
  ,input  logic     byp_resp_v_i
  ,input  mem_msg_s byp_resp_i
  ,output logic     byp_resp_ready_o
  );

  // sel 0 is dmc, 1 is bypass

  // command fan-out, data to both and valid to the selected one
  assign dmc_cmd_v_o     = mem_cmd_v_i & ~sel_i;
  assign byp_cmd_v_o     = mem_cmd_v_i &  sel_i;
  assign dmc_cmd_o       = mem_cmd_i;
  assign byp_cmd_o       = mem_cmd_i;
  assign mem_cmd_ready_o = sel_i ? byp_cmd_ready_i : dmc_cmd_ready_i;

  // response merge
  assign mem_resp_v_o     = sel_i ? byp_resp_v_i : dmc_resp_v_i;
  assign mem_resp_o       = sel_i ? byp_resp_i   : dmc_resp_i;
  assign dmc_resp_ready_o = mem_resp_ready_i & ~sel_i;
  assign byp_resp_ready_o = mem_resp_ready_i &  sel_i;

endmodule

// File: source/chip_tag_client.sv
`timescale 1ns/1ps

module chip_tag_client
  import chip_tag_pkg::*;
  #(parameter type                       payload_t   = logic [tag_payload_width_c-1:0]
   ,parameter logic [tag_id_width_c-1:0] client_id_p = '0
   )
  (input  logic       clk_i
  ,input  logic       rst_n_i
  ,input  tag_write_s tag_write_i
  ,output payload_t   data_o
  ,output logic       new_o
  );

  logic hit;

  assign hit = tag_write_i.v && (tag_write_i.id == client_id_p);

  // low payload bits only, narrower clients drop the rest
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      data_o <= '0;
      new_o  <= 1'b0;
    end else begin
      new_o <= hit;
      if (hit) begin
        data_o <= payload_t'(tag_write_i.payload[$bits(payload_t)-1:0]);
      end
    end
  end

endmodule

// File: source/chip_tag_master.sv
`timescale 1ns/1ps

module chip_tag_master
  import chip_tag_pkg::*;
  (input  logic       clk_i
  ,input  logic       rst_n_i
  ,input  logic       tag_data_i
  ,input  logic       tag_en_i
  ,output tag_write_s tag_write_o
  );

  typedef enum logic {
    idle_e,
    shift_e
  } state_e;

  state_e                         state_r;
  logic [tag_cnt_width_c-1:0]     cnt_r;
  logic [tag_shift_bits_c-1:0]    shift_r;
  logic                           done_r;
  logic                           write_v_r;
  logic [tag_id_width_c-1:0]      write_id_r;
  logic [tag_payload_width_c-1:0] write_payload_r;
  logic                           line_bit;
  logic                           last_bit;

  // line reads as zero while the enable is low
  assign line_bit = tag_en_i & tag_data_i;
  assign last_bit = (state_r == shift_e)
                 && (cnt_r == tag_cnt_width_c'(tag_shift_bits_c - 1));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r <= idle_e;
      cnt_r   <= '0;
      done_r  <= 1'b0;
    end else begin
      done_r <= last_bit;
      case (state_r)
        idle_e: begin
          cnt_r <= '0;
          // start bit
          if (line_bit) begin
            state_r <= shift_e;
          end
        end
        shift_e: begin
          cnt_r <= cnt_r + 1'b1;
          // back to idle right away so a back-to-back start bit is seen
          if (last_bit) begin
            state_r <= idle_e;
          end
        end
        default: begin
          state_r <= idle_e;
        end
      endcase
    end
  end

  // id first, msb first
  always_ff @(posedge clk_i) begin
    if (state_r == shift_e) begin
      shift_r <= {shift_r[tag_shift_bits_c-2:0], line_bit};
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      write_v_r <= 1'b0;
    end else begin
      write_v_r <= done_r;
    end
  end

  always_ff @(posedge clk_i) begin
    if (done_r) begin
      write_id_r      <= shift_r[tag_shift_bits_c-1 -: tag_id_width_c];
      write_payload_r <= shift_r[tag_payload_width_c-1:0];
    end
  end

  assign tag_write_o.v       = write_v_r;
  assign tag_write_o.id      = write_id_r;
  assign tag_write_o.payload = write_payload_r;

endmodule

// File: source/chip_tag_pkg.sv
package chip_tag_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // serial tag protocol

  localparam int tag_id_width_c      = 6;
  localparam int tag_payload_width_c = 8;
  localparam int tag_num_clients_c   = 16;

  // id and payload bits shifted in after the start bit
  localparam int tag_shift_bits_c = tag_id_width_c + tag_payload_width_c;
  localparam int tag_cnt_width_c  = $clog2(tag_shift_bits_c);

  ////////////////////////////////////////////////////////////////////////////
  // client ids

  localparam logic [tag_id_width_c-1:0] tag_core_id_c   = 6'd0;
  localparam logic [tag_id_width_c-1:0] tag_host_id_c   = 6'd1;
  localparam logic [tag_id_width_c-1:0] tag_router_id_c = 6'd2;
  localparam logic [tag_id_width_c-1:0] tag_bypass_id_c = 6'd3;

  // dmc config bytes fill the rest of the id space
  localparam logic [tag_id_width_c-1:0] tag_dmc_base_id_c = 6'd4;
  localparam int tag_dmc_num_c = tag_num_clients_c - int'(tag_dmc_base_id_c);

  localparam int did_width_c = 4;

  ////////////////////////////////////////////////////////////////////////////
  // payload types

  // one write, broadcast to every client
  typedef struct packed {
    logic                           v;
    logic [tag_id_width_c-1:0]      id;
    logic [tag_payload_width_c-1:0] payload;
  } tag_write_s;

  // reset and destination id for core, host and router
  typedef struct packed {
    logic                   reset;
    logic [did_width_c-1:0] did;
  } ctrl_payload_s;

endpackage

// File: source/chip_top.sv
`timescale 1ns/1ps

module chip_top
  import chip_tag_pkg::*;
  import chip_mem_pkg::*;
  (input  logic                   clk_i
  ,input  logic                   rst_n_i
  ,input  logic                   tag_data_i
  ,input  logic                   tag_en_i

  ,output logic                   core_reset_o
  ,output logic [did_width_c-1:0] core_did_o
  ,output logic                   host_reset_o
  ,output logic [did_width_c-1:0] host_did_o
  ,output logic                   router_reset_o
  ,output logic [did_width_c-1:0] router_did_o

  ,output dmc_timing_s            dmc_timing_o
  ,output logic                   dmc_sys_reset_o

  ,input  logic                   mem_cmd_v_i
  ,input  mem_msg_s               mem_cmd_i
  ,output logic                   mem_cmd_ready_o
  ,output logic                   mem_resp_v_o
  ,output mem_msg_s               mem_resp_o
  ,input  logic                   mem_resp_ready_i

  ,output logic                   dmc_cmd_v_o
  ,output mem_msg_s               dmc_cmd_o
  ,input  logic                   dmc_cmd_ready_i
  ,input  logic                   dmc_resp_v_i
  ,input  mem_msg_s               dmc_resp_i
  ,output logic                   dmc_resp_ready_o

  ,output logic                   byp_cmd_v_o
  ,output mem_msg_s               byp_cmd_o
  ,input  logic                   byp_cmd_ready_i
  ,input  logic                   byp_resp_v_i
  ,input  mem_msg_s               byp_resp_i
  ,output logic                   byp_resp_ready_o
  );

  tag_write_s                     tag_write_lo;
  ctrl_payload_s                  core_data_lo;
  ctrl_payload_s                  host_data_lo;
  ctrl_payload_s                  router_data_lo;
  logic [tag_payload_width_c-1:0] bypass_data_lo;

  ////////////////////////////////////////////////////////////////////////////
  // tag master and control clients

  chip_tag_master
    i_tag_master
      (.clk_i      ( clk_i )
      ,.rst_n_i    ( rst_n_i )
      ,.tag_data_i ( tag_data_i )
      ,.tag_en_i   ( tag_en_i )
      ,.tag_write_o( tag_write_lo )
      );

  chip_tag_client #(.payload_t( ctrl_payload_s ), .client_id_p( tag_core_id_c ))
    i_core_client
      (.clk_i      ( clk_i )
      ,.rst_n_i    ( rst_n_i )
      ,.tag_write_i( tag_write_lo )
      ,.data_o     ( core_data_lo )
      ,.new_o      ()
      );

  chip_tag_client #(.payload_t( ctrl_payload_s ), .client_id_p( tag_host_id_c ))
    i_host_client
      (.clk_i      ( clk_i )
      ,.rst_n_i    ( rst_n_i )
      ,.tag_write_i( tag_write_lo )
      ,.data_o     ( host_data_lo )
      ,.new_o      ()
      );

  chip_tag_client #(.payload_t( ctrl_payload_s ), .client_id_p( tag_router_id_c ))
    i_router_client
      (.clk_i      ( clk_i )
      ,.rst_n_i    ( rst_n_i )
      ,.tag_write_i( tag_write_lo )
      ,.data_o     ( router_data_lo )
      ,.new_o      ()
      );

  assign core_reset_o   = core_data_lo.reset;
  assign core_did_o     = core_data_lo.did;
  assign host_reset_o   = host_data_lo.reset;
  assign host_did_o     = host_data_lo.did;
  assign router_reset_o = router_data_lo.reset;
  assign router_did_o   = router_data_lo.did;

  // bypass link byte, bit 0 steers memory traffic
  chip_tag_client
    #(.payload_t  ( logic [tag_payload_width_c-1:0] )
     ,.client_id_p( tag_bypass_id_c )
     )
    i_bypass_client
      (.clk_i      ( clk_i )
      ,.rst_n_i    ( rst_n_i )
      ,.tag_write_i( tag_write_lo )
      ,.data_o     ( bypass_data_lo )
      ,.new_o      ()
      );

  ////////////////////////////////////////////////////////////////////////////
  // dmc configuration and memory steering

  chip_dmc_cfg
    i_dmc_cfg
      (.clk_i          ( clk_i )
      ,.rst_n_i        ( rst_n_i )
      ,.tag_write_i    ( tag_write_lo )
      ,.dmc_timing_o   ( dmc_timing_o )
      ,.dmc_sys_reset_o( dmc_sys_reset_o )
      );

  chip_mem_switch
    i_mem_switch
      (.sel_i           ( bypass_data_lo[0] )
      ,.mem_cmd_v_i     ( mem_cmd_v_i )
      ,.mem_cmd_i       ( mem_cmd_i )
      ,.mem_cmd_ready_o ( mem_cmd_ready_o )
      ,.mem_resp_v_o    ( mem_resp_v_o )
      ,.mem_resp_o      ( mem_resp_o )
      ,.mem_resp_ready_i( mem_resp_ready_i )
      ,.dmc_cmd_v_o     ( dmc_cmd_v_o )
      ,.dmc_cmd_o       ( dmc_cmd_o )
      ,.dmc_cmd_ready_i ( dmc_cmd_ready_i )
      ,.dmc_resp_v_i    ( dmc_resp_v_i )
      ,.dmc_resp_i      ( dmc_resp_i )
      ,.dmc_resp_ready_o( dmc_resp_ready_o )
      ,.byp_cmd_v_o     ( byp_cmd_v_o )
      ,.byp_cmd_o       ( byp_cmd_o )
      ,.byp_cmd_ready_i ( byp_cmd_ready_i )
      ,.byp_resp_v_i    ( byp_resp_v_i )
      ,.byp_resp_i      ( byp_resp_i )
      ,.byp_resp_ready_o( byp_resp_ready_o )
      );

endmodule

// File: tb.f
source/chip_tag_pkg.sv
source/chip_mem_pkg.sv
source/chip_tag_master.sv
source/chip_tag_client.sv
source/chip_dmc_cfg.sv
source/chip_mem_switch.sv
source/chip_top.sv
sim/tb_clk_gen.sv
sim/tb_chip_top.sv
